// ==== Bender.yml ====
package:
  name: cgra_conf

export_include_dirs:
  - .

sources:
  - cgra_conf_pkg.sv
  - sync_fifo.sv
  - conf_line_fetch.sv
  - cgra_conf_ctrl.sv
  - pe_conf_dist.sv
  - cgra_conf_top.sv
  - target: test
    files:
      - tb_cgra_conf.sv

// ==== cgra_conf_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cgra_conf_defs.svh"

module cgra_conf_ctrl import cgra_conf_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic start,
  input wire logic line_empty,
  input wire conf_line_t line_data,
  input wire logic word_almost_full,
  input wire logic word_fifo_empty,
  input wire logic dist_busy,
  output logic fetch_en,
  output logic line_pop,
  output logic word_push,
  output conf_word_t word,
  output logic [`CONF_FIFO_MASK_W-1:0] read_fifo_mask,
  output logic [`CONF_FIFO_MASK_W-1:0] write_fifo_mask,
  output logic done
);

  localparam int WIL_W = $clog2(`CONF_WORDS_PER_LINE + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_UNPACK,
    ST_DRAIN,
    ST_DONE
  } state_t;

  state_t state;
  conf_hdr_t hdr;
  conf_line_t line_sr;
  logic [WIL_W-1:0] wil;  // words left in line_sr
  logic [`CONF_QTD_W-1:0] qtd;
  logic [`CONF_QTD_W-1:0] word_cnt;
  logic last_word;

  assign hdr.qtd = line_data[`CONF_HDR_QTD_LSB +: `CONF_QTD_W];
  assign hdr.read_fifo_mask = line_data[`CONF_HDR_RMASK_LSB +: `CONF_FIFO_MASK_W];
  assign hdr.write_fifo_mask = line_data[`CONF_HDR_WMASK_LSB +: `CONF_FIFO_MASK_W];

  assign word = conf_word_t'(line_sr[`CONF_WORD_W-1:0]);  // lowest word first
  assign word_push = (state == ST_UNPACK) && (wil != '0) && !word_almost_full;
  assign last_word = word_push && (word_cnt + 1'b1 == qtd);

  // refill as the last word of a line leaves
  always_comb begin
    case (state)
      ST_HEADER: line_pop = !line_empty;
      ST_UNPACK: line_pop = !line_empty && !last_word &&
                            ((wil == '0) || ((wil == WIL_W'(1)) && word_push));
      default: line_pop = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      fetch_en <= 1'b0;
      done <= 1'b0;
      read_fifo_mask <= '0;
      write_fifo_mask <= '0;
      wil <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_HEADER;
            fetch_en <= 1'b1;
            wil <= '0;
            word_cnt <= '0;
          end
        end
        ST_HEADER: begin
          if (line_pop) begin
            read_fifo_mask <= hdr.read_fifo_mask;
            write_fifo_mask <= hdr.write_fifo_mask;
            state <= (hdr.qtd == '0) ? ST_DRAIN : ST_UNPACK;
          end
        end
        ST_UNPACK: begin
          if (word_push) word_cnt <= word_cnt + 1'b1;
          if (line_pop) begin
            wil <= WIL_W'(`CONF_WORDS_PER_LINE);
          end else if (word_push) begin
            wil <= wil - 1'b1;
          end
          if (last_word) state <= ST_DRAIN;  // rest of line is dropped
        end
        ST_DRAIN: begin
          if (word_fifo_empty && !dist_busy) begin
            state <= ST_DONE;
            done <= 1'b1;
            fetch_en <= 1'b0;
          end
        end
        default: ;  // ST_DONE holds until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_HEADER) && line_pop) qtd <= hdr.qtd;
    if (state == ST_UNPACK) begin
      if (line_pop) begin
        line_sr <= line_data;
      end else if (word_push) begin
        line_sr <= line_sr >> `CONF_WORD_W;
      end
    end
  end

  // never more than qtd words go out
  assert property (@(posedge clk) disable iff (rst)
    word_push |-> word_cnt < qtd);

  // nothing may still be buffered downstream once done is up
  assert property (@(posedge clk) disable iff (rst)
    done |=> done && word_fifo_empty && !dist_busy);

endmodule

`default_nettype wire

// ==== cgra_conf_defs.svh ====
`ifndef CGRA_CONF_DEFS_SVH
`define CGRA_CONF_DEFS_SVH

`define CONF_LINE_W 512
`define CONF_WORD_W 64
`define CONF_WORDS_PER_LINE 8
`define CONF_PE_ID_W 8
`define CONF_PAYLOAD_W (`CONF_WORD_W - `CONF_PE_ID_W)

`define CONF_ADDR_W 32  // line address, not byte address
`define CONF_QTD_W 32

`define CONF_LINE_FIFO_DEPTH 4
`define CONF_WORD_FIFO_DEPTH 8
`define CONF_FIFO_CNT_W 4  // wide enough for the deeper fifo
`define CONF_FIFO_MASK_W 8

// field positions in the header line
`define CONF_HDR_QTD_LSB 0
`define CONF_HDR_RMASK_LSB 32
`define CONF_HDR_WMASK_LSB 64

`endif

// ==== cgra_conf_pkg.sv ====
`default_nettype none

package cgra_conf_pkg;

`include "cgra_conf_defs.svh"

  typedef logic [`CONF_LINE_W-1:0] conf_line_t;

  // pe_id sits in the top byte of each word
  typedef struct packed {
    logic [`CONF_PE_ID_W-1:0] pe_id;
    logic [`CONF_PAYLOAD_W-1:0] payload;
  } conf_word_t;

  typedef struct packed {
    logic [`CONF_QTD_W-1:0] qtd;
    logic [`CONF_FIFO_MASK_W-1:0] read_fifo_mask;
    logic [`CONF_FIFO_MASK_W-1:0] write_fifo_mask;
  } conf_hdr_t;

  typedef struct packed {
    logic valid;
    logic [`CONF_PE_ID_W-1:0] pe_id;
    logic [`CONF_PAYLOAD_W-1:0] payload;
  } pe_write_t;

endpackage

`default_nettype wire

// ==== cgra_conf_testdata.txt ====
// record: base_addr stall_threshold(of 16) line_count expected_strobes
// then line_count memory lines from base_addr up, two rows of four 64-bit words per line,
// lowest word first; a word is pe_id[63:56] payload[55:0]
// set 1: header qtd b, rmask a5, wmask 3c; last five words of the last line are dropped
40 6 3 b
ffffffa50000000b 1234567800000c3c 00000000deadbeef 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
01000000000a0001 0200000000b00002 03000000000c0003 0400000000d00004
05a5a5a5a5a50005 0600000000000006 07ffffffffff0007 0812345678900008
0923456789ab0009 0a00000000e0000a 0b000000f000000b c0ffee00c0ffee0c
d0000000000000dd e0000000000000ee f0000000000000ff 11deadbeef000010
// set 2: header qtd 0, rmask 5a, wmask c3; no words delivered
1000 8 1 0
0000005a00000000 00000000000000c3 5555555555555555 aaaaaaaaaaaaaaaa
0123456789abcdef fedcba9876543210 0f0f0f0f0f0f0f0f f0f0f0f0f0f0f0f0

// ==== cgra_conf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cgra_conf_defs.svh"

module cgra_conf_top import cgra_conf_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic start,
  input wire logic [`CONF_ADDR_W-1:0] base_addr,
  input wire conf_line_t mem_rdata,
  input wire logic mem_rvalid,
  input wire logic pe_stall,
  output logic mem_req,
  output logic [`CONF_ADDR_W-1:0] mem_addr,
  output pe_write_t pe_wr,
  output logic [`CONF_FIFO_MASK_W-1:0] read_fifo_mask,
  output logic [`CONF_FIFO_MASK_W-1:0] write_fifo_mask,
  output logic done
);

  logic fetch_en;
  logic line_push;
  logic line_pop;
  logic line_flush;
  logic line_empty;
  logic [`CONF_FIFO_CNT_W-1:0] line_count;
  conf_line_t fetch_line;
  conf_line_t head_line;
  logic word_push;
  logic word_pop;
  logic word_empty;
  logic word_almost_full;
  logic dist_busy;
  conf_word_t ctrl_word;
  conf_word_t head_word;

  conf_line_fetch u_fetch (
    .clk(clk),
    .rst(rst),
    .fetch_en(fetch_en),
    .base_addr(base_addr),
    .mem_rdata(mem_rdata),
    .mem_rvalid(mem_rvalid),
    .fifo_count(line_count),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .line_push(line_push),
    .line_data(fetch_line),
    .line_flush(line_flush)
  );

  sync_fifo #(.item_t(conf_line_t)) line_fifo (
    .clk(clk),
    .rst(rst),
    .flush(line_flush),
    .push(line_push),
    .din(fetch_line),
    .pop(line_pop),
    .dout(head_line),
    .empty(line_empty),
    .almost_full(),  // fetch budget uses count
    .count(line_count)
  );

  cgra_conf_ctrl u_ctrl (
    .clk(clk),
    .rst(rst),
    .start(start),
    .line_empty(line_empty),
    .line_data(head_line),
    .word_almost_full(word_almost_full),
    .word_fifo_empty(word_empty),
    .dist_busy(dist_busy),
    .fetch_en(fetch_en),
    .line_pop(line_pop),
    .word_push(word_push),
    .word(ctrl_word),
    .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask),
    .done(done)
  );

  sync_fifo #(.item_t(conf_word_t)) word_fifo (
    .clk(clk),
    .rst(rst),
    .flush(1'b0),
    .push(word_push),
    .din(ctrl_word),
    .pop(word_pop),
    .dout(head_word),
    .empty(word_empty),
    .almost_full(word_almost_full),
    .count()
  );

  pe_conf_dist u_dist (
    .clk(clk),
    .rst(rst),
    .word_empty(word_empty),
    .word(head_word),
    .pe_stall(pe_stall),
    .word_pop(word_pop),
    .pe_wr(pe_wr),
    .busy(dist_busy)
  );

endmodule

`default_nettype wire

// ==== conf_line_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cgra_conf_defs.svh"

module conf_line_fetch import cgra_conf_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic fetch_en,
  input wire logic [`CONF_ADDR_W-1:0] base_addr,
  input wire conf_line_t mem_rdata,
  input wire logic mem_rvalid,
  input wire logic [`CONF_FIFO_CNT_W-1:0] fifo_count,
  output logic mem_req,
  output logic [`CONF_ADDR_W-1:0] mem_addr,
  output logic line_push,
  output conf_line_t line_data,
  output logic line_flush
);

  logic [`CONF_FIFO_CNT_W-1:0] outstanding;
  logic [`CONF_ADDR_W-1:0] next_addr;
  logic fetch_en_q;
  logic issue;

  // in-flight lines plus buffered lines must fit the line fifo
  assign issue = fetch_en &&
                 (int'(outstanding) + int'(fifo_count) < `CONF_LINE_FIFO_DEPTH);

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req <= 1'b0;
      outstanding <= '0;
      fetch_en_q <= 1'b0;
    end else begin
      mem_req <= issue;
      fetch_en_q <= fetch_en;
      case ({issue, mem_rvalid})
        2'b10: outstanding <= outstanding + 1'b1;
        2'b01: outstanding <= outstanding - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!fetch_en) begin
      next_addr <= base_addr;  // rearm while idle
    end else if (issue) begin
      next_addr <= next_addr + 1'b1;
    end
    if (issue) mem_addr <= next_addr;
  end

  // returns after disable only count down
  assign line_push = mem_rvalid && fetch_en;
  assign line_data = mem_rdata;
  assign line_flush = fetch_en_q && !fetch_en;

  assert property (@(posedge clk) disable iff (rst)
    mem_rvalid |-> outstanding != '0);

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
cgra_conf_pkg.sv
sync_fifo.sv
conf_line_fetch.sv
cgra_conf_ctrl.sv
pe_conf_dist.sv
cgra_conf_top.sv
tb_cgra_conf.sv

// ==== pe_conf_dist.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cgra_conf_defs.svh"

module pe_conf_dist import cgra_conf_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic word_empty,
  input wire conf_word_t word,
  input wire logic pe_stall,
  output logic word_pop,
  output pe_write_t pe_wr,
  output logic busy
);

  logic pend;  // hold register occupied
  conf_word_t hold;

  // a pending word always leaves in a cycle where a pop is allowed
  assign word_pop = !word_empty && !pe_stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= 1'b0;
    end else if (!pe_stall) begin
      pend <= word_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (word_pop) hold <= word;
  end

  always_comb begin
    pe_wr = '0;
    if (pend && !pe_stall) begin
      pe_wr.valid = 1'b1;
      pe_wr.pe_id = hold.pe_id;
      pe_wr.payload = hold.payload;
    end
  end

  assign busy = pend;

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cgra_conf_defs.svh"

module sync_fifo #(
  parameter type item_t = logic [`CONF_WORD_W-1:0]
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic flush,
  input wire logic push,
  input wire item_t din,
  input wire logic pop,
  output item_t dout,
  output logic empty,
  output logic almost_full,
  output logic [`CONF_FIFO_CNT_W-1:0] count
);

  // line-wide payloads get the shallow line depth
  localparam int DEPTH = ($bits(item_t) == `CONF_LINE_W) ?
                         `CONF_LINE_FIFO_DEPTH : `CONF_WORD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  item_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  assign dout = mem[rd_ptr];
  assign empty = (count == '0);
  assign almost_full = (int'(count) >= DEPTH - 1);  // one slot short of full

  assert property (@(posedge clk) disable iff (rst || flush)
    push |-> int'(count) < DEPTH);

  assert property (@(posedge clk) disable iff (rst || flush)
    pop |-> !empty);

endmodule

`default_nettype wire

// ==== tb_cgra_conf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cgra_conf_defs.svh"

module tb_cgra_conf import cgra_conf_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int TD_WORDS = 40;
  localparam int NUM_SETS = 2;
  localparam int TIMEOUT_CYCLES = 1000;
  localparam int HOLD_CYCLES = 12;

  logic clk;
  logic rst;
  logic start;
  logic [`CONF_ADDR_W-1:0] base_addr;
  conf_line_t mem_rdata;
  logic mem_rvalid;
  logic pe_stall;
  logic mem_req;
  logic [`CONF_ADDR_W-1:0] mem_addr;
  pe_write_t pe_wr;
  logic [`CONF_FIFO_MASK_W-1:0] read_fifo_mask;
  logic [`CONF_FIFO_MASK_W-1:0] write_fifo_mask;
  logic done;

  logic [`CONF_WORD_W-1:0] tdata [TD_WORDS];
  integer seed = 32'h2dec_f67a;

  logic [`CONF_ADDR_W-1:0] set_base;
  int set_thr;  // stall odds out of 16
  int set_lines;
  int set_exp;
  int set_ptr;  // header line in tdata
  conf_hdr_t hdr_exp;

  conf_word_t exp_words [$];
  int strobes;
  logic [`CONF_ADDR_W-1:0] next_addr;
  logic [`CONF_ADDR_W-1:0] req_addr_q [$];
  int req_due_q [$];
  int last_due;
  int in_flight;
  int cyc;
  logic nxt_rvalid;
  conf_line_t nxt_rdata;
  logic nxt_stall;

  cgra_conf_top DUT (
    .clk(clk),
    .rst(rst),
    .start(start),
    .base_addr(base_addr),
    .mem_rdata(mem_rdata),
    .mem_rvalid(mem_rvalid),
    .pe_stall(pe_stall),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .pe_wr(pe_wr),
    .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask),
    .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input conf_word_t got, input conf_word_t exp);
    if (got !== exp)
      stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_masks(input conf_hdr_t got, input conf_hdr_t exp);
    if (got.read_fifo_mask !== exp.read_fifo_mask)
      stop_run($sformatf("[ERROR] read_fifo_mask got %h expected %h",
                         got.read_fifo_mask, exp.read_fifo_mask));
    if (got.write_fifo_mask !== exp.write_fifo_mask)
      stop_run($sformatf("[ERROR] write_fifo_mask got %h expected %h",
                         got.write_fifo_mask, exp.write_fifo_mask));
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("[ERROR] done got %h expected %h", got, exp));
  endtask

  task automatic check_addr(input string name, input logic [`CONF_ADDR_W-1:0] got,
                            input logic [`CONF_ADDR_W-1:0] exp);
    if (got !== exp)
      stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  // memory contents, unloaded addresses get an address-derived fill
  function automatic conf_line_t line_at(input logic [`CONF_ADDR_W-1:0] addr);
    conf_line_t line;
    logic [`CONF_ADDR_W-1:0] idx;
    idx = addr - set_base;
    if (idx < set_lines) begin
      for (int w = 0; w < `CONF_WORDS_PER_LINE; w++)
        line[w * `CONF_WORD_W +: `CONF_WORD_W] = tdata[set_ptr + idx * 8 + w];
    end else begin
      line = {(`CONF_LINE_W / `CONF_ADDR_W){addr ^ 32'h5a5a_c3c3}};
    end
    return line;
  endfunction

  function automatic conf_hdr_t masks_now();
    conf_hdr_t cur;
    cur = '0;
    cur.read_fifo_mask = read_fifo_mask;
    cur.write_fifo_mask = write_fifo_mask;
    return cur;
  endfunction

  task automatic load_set(input int ptr);
    conf_line_t line;
    int k;
    set_base = tdata[ptr][`CONF_ADDR_W-1:0];
    set_thr = int'(tdata[ptr + 1]);
    set_lines = int'(tdata[ptr + 2]);
    set_exp = int'(tdata[ptr + 3]);
    set_ptr = ptr + 4;
    line = line_at(set_base);
    hdr_exp = '0;
    hdr_exp.read_fifo_mask = line[`CONF_HDR_RMASK_LSB +: `CONF_FIFO_MASK_W];
    hdr_exp.write_fifo_mask = line[`CONF_HDR_WMASK_LSB +: `CONF_FIFO_MASK_W];
    exp_words.delete();
    for (k = 0; k < set_exp; k++) begin
      line = line_at(set_base + 1 + k / `CONF_WORDS_PER_LINE);  // lines after header
      exp_words.push_back(line[(k % `CONF_WORDS_PER_LINE) * `CONF_WORD_W +: `CONF_WORD_W]);
    end
    strobes = 0;
    next_addr = set_base;
    base_addr = set_base;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done();
    int i;
    for (i = 0; i < TIMEOUT_CYCLES && !done; i++)
      @(negedge clk);
    if (!done)
      stop_run("timeout while waiting for done to rise");
  endtask

  // memory model and scoreboard, drive at negedge, sample a quarter later
  initial begin
    conf_word_t got;
    conf_word_t exp_w;
    int due;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    pe_stall = 1'b0;
    nxt_rvalid = 1'b0;
    nxt_rdata = '0;
    nxt_stall = 1'b0;
    cyc = 0;
    forever begin
      @(negedge clk);
      mem_rvalid = nxt_rvalid;
      mem_rdata = nxt_rdata;
      pe_stall = nxt_stall;
      #(CLK_PERIOD / 4);
      cyc++;
      nxt_rvalid = 1'b0;
      if (rst) begin
        req_addr_q.delete();
        req_due_q.delete();
        in_flight = 0;
        last_due = 0;
        nxt_stall = 1'b0;
      end else begin
        if (mem_rvalid)
          in_flight--;
        if (mem_req) begin
          check_addr("mem_addr", mem_addr, next_addr);
          next_addr++;
          in_flight++;
          if (in_flight > `CONF_LINE_FIFO_DEPTH)
            stop_run("more than four memory lines outstanding");
          due = cyc + int'({$random(seed)} % 6);  // 1 to 6 cycles
          if (due <= last_due)
            due = last_due + 1;  // in order
          last_due = due;
          req_addr_q.push_back(mem_addr);
          req_due_q.push_back(due);
        end
        if (req_due_q.size() > 0 && req_due_q[0] <= cyc) begin
          nxt_rvalid = 1'b1;
          nxt_rdata = line_at(req_addr_q.pop_front());
          void'(req_due_q.pop_front());
        end
        if (pe_wr.valid) begin
          if (pe_stall)
            stop_run("pe_wr strobe seen while pe_stall is high");
          if (exp_words.size() == 0)
            stop_run("pe_wr strobe beyond the expected word count");
          got.pe_id = pe_wr.pe_id;
          got.payload = pe_wr.payload;
          exp_w = exp_words.pop_front();
          check_word("pe_wr", got, exp_w);
          strobes++;
        end
        nxt_stall = ({$random(seed)} % 16) < set_thr;
      end
    end
  end

  initial begin
    int ptr;
    int s;
    int h;
    rst = 1'b1;
    start = 1'b0;
    base_addr = '0;
    $readmemh("cgra_conf_testdata.txt", tdata);
    ptr = 0;
    for (s = 0; s < NUM_SETS; s++) begin
      load_set(ptr);
      apply_reset();
      check_done(done, 1'b0);
      check_masks(masks_now(), '0);
      pulse_start();
      wait_done();
      check_count("pe_wr strobes", strobes, set_exp);
      check_masks(masks_now(), hdr_exp);
      for (h = 0; h < HOLD_CYCLES; h++) begin
        @(negedge clk);
        check_done(done, 1'b1);  // sticky until reset
      end
      ptr = set_ptr + set_lines * `CONF_WORDS_PER_LINE;
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
